//--- verilog/rv32i_types.sv
package rv32i_types;

    // Data word for operands, results and the PC
    typedef logic [31:0] word_t;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    // Branch compare operations
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } cmp_op_t;

    // RV32M multiply flavours
    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mul_type_t;

    // Operand 1 source
    typedef enum logic [1:0] {
        RS1,
        PC,
        ZERO
    } op1_sel_t;

    // Operand 2 source
    typedef enum logic {
        RS2,
        IMM
    } op2_sel_t;

    // Which unit produces the result
    typedef enum logic [1:0] {
        ALU,
        BRANCH,
        JUMP,
        MULT
    } fu_kind_t;

endpackage

//--- verilog/ooo_types.sv
package ooo_types;

    // Issue ways
    localparam int SS = 2;

    // Machine sizes
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 8;

    // Cycles from the issue edge to a multiply result
    localparam int MUL_LATENCY = 33;

    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // One issued operation
    typedef struct packed {
        logic                   valid;
        rv32i_types::fu_kind_t  kind;
        rv32i_types::alu_op_t   alu_op;
        rv32i_types::cmp_op_t   cmp_op;
        rv32i_types::mul_type_t mul_type;
        rv32i_types::op1_sel_t  op1_sel;
        rv32i_types::op2_sel_t  op2_sel;
        phys_reg_t              ps1;
        phys_reg_t              ps2;
        phys_reg_t              pd;
        rob_idx_t               rob_idx;
        rv32i_types::word_t     pc;
        rv32i_types::word_t     imm;
    } fu_input_t;

    // One completed operation on a result bus
    typedef struct packed {
        logic               valid;
        phys_reg_t          pd;
        rob_idx_t           rob_idx;
        rv32i_types::word_t value;
        logic               branch_taken;
        rv32i_types::word_t target;
    } fu_output_t;

    // Register file write port
    typedef struct packed {
        logic               en;
        phys_reg_t          pd;
        rv32i_types::word_t value;
    } prf_write_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32i_types::alu_op_t op,
    input  rv32i_types::word_t   a,
    input  rv32i_types::word_t   b,
    output rv32i_types::word_t   f
);

    logic [4:0] shamt;

    // Shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        unique case (op)
            rv32i_types::ADD:  f = a + b;
            rv32i_types::SUB:  f = a - b;
            rv32i_types::SLL:  f = a << shamt;
            rv32i_types::SLT:  f = {31'b0, $signed(a) < $signed(b)};
            rv32i_types::SLTU: f = {31'b0, a < b};
            rv32i_types::XOR:  f = a ^ b;
            rv32i_types::SRL:  f = a >> shamt;
            rv32i_types::SRA:  f = $signed(a) >>> shamt;
            rv32i_types::OR:   f = a | b;
            rv32i_types::AND:  f = a & b;
            default:           f = '0;
        endcase
    end

endmodule

//--- verilog/cmp.sv
`timescale 1ns/1ps

module cmp (
    input  rv32i_types::cmp_op_t op,
    input  rv32i_types::word_t   a,
    input  rv32i_types::word_t   b,
    output logic                 taken
);

    always_comb begin
        unique case (op)
            rv32i_types::BEQ:  taken = (a == b);
            rv32i_types::BNE:  taken = (a != b);
            rv32i_types::BLT:  taken = ($signed(a) < $signed(b));
            rv32i_types::BGE:  taken = ($signed(a) >= $signed(b));
            rv32i_types::BLTU: taken = (a < b);
            rv32i_types::BGEU: taken = (a >= b);
            default:           taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  rv32i_types::mul_type_t mul_type,
    input  rv32i_types::word_t     a,
    input  rv32i_types::word_t     b,
    output rv32i_types::word_t     p,
    output logic                   busy,
    output logic                   done
);

    // The start edge does the first iteration, RUN does the other 31
    localparam int LAST_ITER = ooo_types::MUL_LATENCY - 2;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t state;
    logic [$clog2(LAST_ITER+1)-1:0] count;

    logic [63:0] acc;
    logic [63:0] mcand;
    logic [31:0] mplier;
    logic        neg;
    rv32i_types::mul_type_t type_q;

    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic        load;
    logic [63:0] src_acc;
    logic [63:0] src_mcand;
    logic [31:0] src_mplier;
    logic [63:0] acc_next;
    logic [63:0] product;

    // Operand signedness follows the multiply flavour
    assign a_neg = a[31] && (mul_type == rv32i_types::MULH || mul_type == rv32i_types::MULHSU);
    assign b_neg = b[31] && (mul_type == rv32i_types::MULH);
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    assign load = (state == IDLE) && start;

    // On the start edge the step works straight on the magnitudes
    assign src_acc    = load ? 64'b0 : acc;
    assign src_mcand  = load ? {32'b0, a_mag} : mcand;
    assign src_mplier = load ? b_mag : mplier;
    assign acc_next   = src_acc + (src_mplier[0] ? src_mcand : 64'b0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        count <= 1;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == LAST_ITER) begin
                        state <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load || state == RUN) begin
            acc    <= acc_next;
            mcand  <= src_mcand << 1;
            mplier <= src_mplier >> 1;
        end
        if (load) begin
            neg    <= a_neg ^ b_neg;
            type_q <= mul_type;
        end
    end

    // Sign fix on the magnitude product
    assign product = neg ? -acc : acc;
    assign p       = (type_q == rv32i_types::MUL) ? product[31:0] : product[63:32];

    assign busy = (state != IDLE);
    assign done = (state == DONE);

endmodule

//--- verilog/fu_wrapper.sv
`timescale 1ns/1ps

module fu_wrapper (
    input  logic                   clk,
    input  logic                   rst,
    input  ooo_types::fu_input_t   issue     [ooo_types::SS],
    input  rv32i_types::word_t     rs1_value [ooo_types::SS],
    input  rv32i_types::word_t     rs2_value [ooo_types::SS],
    output ooo_types::phys_reg_t   ps1_req   [ooo_types::SS],
    output ooo_types::phys_reg_t   ps2_req   [ooo_types::SS],
    output ooo_types::fu_output_t  result    [ooo_types::SS],
    output logic                   mult_busy [ooo_types::SS]
);

    for (genvar i = 0; i < ooo_types::SS; i++) begin : g_way
        rv32i_types::word_t    op1;
        rv32i_types::word_t    op2;
        rv32i_types::word_t    alu_f;
        rv32i_types::word_t    mul_p;
        rv32i_types::word_t    jump_target;
        logic                  taken;
        logic                  mul_start;
        logic                  mul_done;
        ooo_types::phys_reg_t  mul_pd;
        ooo_types::rob_idx_t   mul_rob;
        ooo_types::fu_output_t next_result;

        // Register file read requests
        assign ps1_req[i] = issue[i].ps1;
        assign ps2_req[i] = issue[i].ps2;

        always_comb begin
            unique case (issue[i].op1_sel)
                rv32i_types::RS1:  op1 = rs1_value[i];
                rv32i_types::PC:   op1 = issue[i].pc;
                rv32i_types::ZERO: op1 = '0;
                default:           op1 = '0;
            endcase
        end

        assign op2 = (issue[i].op2_sel == rv32i_types::IMM) ? issue[i].imm : rs2_value[i];

        alu u_alu (
            .op (issue[i].alu_op),
            .a  (op1),
            .b  (op2),
            .f  (alu_f)
        );

        // Branches always compare the register values
        cmp u_cmp (
            .op    (issue[i].cmp_op),
            .a     (rs1_value[i]),
            .b     (rs2_value[i]),
            .taken (taken)
        );

        assign mul_start = issue[i].valid && (issue[i].kind == rv32i_types::MULT);

        shift_add_multiplier u_mult (
            .clk      (clk),
            .rst      (rst),
            .start    (mul_start),
            .mul_type (issue[i].mul_type),
            .a        (rs1_value[i]),
            .b        (rs2_value[i]),
            .p        (mul_p),
            .busy     (mult_busy[i]),
            .done     (mul_done)
        );

        // JALR drops the low target bit, JAL has an even PC anyway
        always_comb begin
            jump_target = op1 + issue[i].imm;
            if (issue[i].op1_sel == rv32i_types::RS1) begin
                jump_target[0] = 1'b0;
            end
        end

        always_comb begin
            next_result              = '0;
            next_result.valid        = issue[i].valid;
            next_result.pd           = issue[i].pd;
            next_result.rob_idx      = issue[i].rob_idx;
            unique case (issue[i].kind)
                rv32i_types::ALU: begin
                    next_result.value = alu_f;
                end
                rv32i_types::BRANCH: begin
                    next_result.pd           = '0;
                    next_result.branch_taken = taken;
                    next_result.target       = issue[i].pc + issue[i].imm;
                end
                rv32i_types::JUMP: begin
                    next_result.value  = issue[i].pc + 32'd4;
                    next_result.target = jump_target;
                end
                default: begin
                    // Multiply completes later through the multiplier
                    next_result.valid = 1'b0;
                end
            endcase
            // Multiply finishing takes the bus
            if (mul_done) begin
                next_result         = '0;
                next_result.valid   = 1'b1;
                next_result.pd      = mul_pd;
                next_result.rob_idx = mul_rob;
                next_result.value   = mul_p;
            end
        end

        // Destination of the running multiply
        always_ff @(posedge clk) begin
            if (mul_start && !mult_busy[i]) begin
                mul_pd  <= issue[i].pd;
                mul_rob <= issue[i].rob_idx;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                result[i] <= '0;
            end else begin
                result[i] <= next_result;
            end
        end
    end

endmodule

//--- verilog/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_types::phys_reg_t  raddr1 [ooo_types::SS],
    input  ooo_types::phys_reg_t  raddr2 [ooo_types::SS],
    input  ooo_types::prf_write_t wr     [ooo_types::SS],
    input  ooo_types::prf_write_t ext_write,
    output rv32i_types::word_t    rdata1 [ooo_types::SS],
    output rv32i_types::word_t    rdata2 [ooo_types::SS]
);

    rv32i_types::word_t regs [ooo_types::PHYS_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ooo_types::PHYS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // External port first so the way ports override it
            if (ext_write.en && ext_write.pd != '0) begin
                regs[ext_write.pd] <= ext_write.value;
            end
            for (int w = 0; w < ooo_types::SS; w++) begin
                if (wr[w].en && wr[w].pd != '0) begin
                    regs[wr[w].pd] <= wr[w].value;
                end
            end
        end
    end

    // Register 0 is never written, so it reads as zero
    always_comb begin
        for (int w = 0; w < ooo_types::SS; w++) begin
            rdata1[w] = regs[raddr1[w]];
            rdata2[w] = regs[raddr2[w]];
        end
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_types::fu_input_t  issue     [ooo_types::SS],
    input  ooo_types::prf_write_t ext_write,
    output ooo_types::fu_output_t result    [ooo_types::SS],
    output logic                  mult_busy [ooo_types::SS]
);

    ooo_types::phys_reg_t  ps1_req   [ooo_types::SS];
    ooo_types::phys_reg_t  ps2_req   [ooo_types::SS];
    rv32i_types::word_t    rs1_value [ooo_types::SS];
    rv32i_types::word_t    rs2_value [ooo_types::SS];
    ooo_types::prf_write_t wb        [ooo_types::SS];

    // Each result bus is also its way's writeback port
    for (genvar i = 0; i < ooo_types::SS; i++) begin : g_wb
        assign wb[i].en    = result[i].valid;
        assign wb[i].pd    = result[i].pd;
        assign wb[i].value = result[i].value;
    end

    phys_regfile u_prf (
        .clk       (clk),
        .rst       (rst),
        .raddr1    (ps1_req),
        .raddr2    (ps2_req),
        .wr        (wb),
        .ext_write (ext_write),
        .rdata1    (rs1_value),
        .rdata2    (rs2_value)
    );

    fu_wrapper u_fu (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .ps1_req   (ps1_req),
        .ps2_req   (ps2_req),
        .result    (result),
        .mult_busy (mult_busy)
    );

endmodule

//--- sim/execute_stage_properties.sv
`timescale 1ns/1ps

module execute_stage_properties (
    input logic                  clk,
    input logic                  rst,
    input ooo_types::fu_input_t  issue     [ooo_types::SS],
    input ooo_types::fu_output_t result    [ooo_types::SS],
    input logic                  mult_busy [ooo_types::SS]
);

    // Failed assertions so far
    int fail_count = 0;

    for (genvar i = 0; i < ooo_types::SS; i++) begin : g_way
        // Single-cycle units answer on the next edge
        alu_one_cycle: assert property (@(posedge clk) disable iff (rst)
            (issue[i].valid && issue[i].kind == rv32i_types::ALU) |=> result[i].valid)
            else begin
                $error("ALU issue on way %0d without a result one cycle later", i);
                fail_count = fail_count + 1;
            end

        no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
            mult_busy[i] |-> !issue[i].valid)
            else begin
                $error("Issue on way %0d while its multiplier is busy", i);
                fail_count = fail_count + 1;
            end

        idle_after_reset: assert property (@(posedge clk) rst |=> !mult_busy[i])
            else begin
                $error("mult_busy high on way %0d right after reset", i);
                fail_count = fail_count + 1;
            end
    end

endmodule

bind fu_wrapper execute_stage_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .result    (result),
    .mult_busy (mult_busy)
);

//--- sim/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;

    // Longest test is the multiply sweep at about 460 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk;
    logic                  rst;
    ooo_types::fu_input_t  issue     [ooo_types::SS];
    ooo_types::prf_write_t ext_write;
    ooo_types::fu_output_t result    [ooo_types::SS];
    logic                  mult_busy [ooo_types::SS];

    int seed;
    int cycle_count = 0;

    execute_stage UUT (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .ext_write (ext_write),
        .result    (result),
        .mult_busy (mult_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // A failed bound assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (UUT.u_fu.u_properties.fail_count != 0) begin
            $display("A bound assertion on the functional units failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failed");
        end
    end

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_result(input string name, input ooo_types::fu_output_t res,
                                input rv32i_types::word_t value,
                                input ooo_types::phys_reg_t pd,
                                input ooo_types::rob_idx_t rob_idx);
        check_equal({name, " valid"}, 1, res.valid);
        check_equal({name, " value"}, value, res.value);
        check_equal({name, " pd"}, pd, res.pd);
        check_equal({name, " rob_idx"}, rob_idx, res.rob_idx);
    endtask

    // Valid issue with register operands and all selects at their zero encoding
    function automatic ooo_types::fu_input_t new_issue(input rv32i_types::fu_kind_t kind,
                                                       input ooo_types::phys_reg_t ps1,
                                                       input ooo_types::phys_reg_t ps2,
                                                       input ooo_types::phys_reg_t pd,
                                                       input ooo_types::rob_idx_t rob_idx);
        ooo_types::fu_input_t op;
        op         = '0;
        op.valid   = 1'b1;
        op.kind    = kind;
        op.ps1     = ps1;
        op.ps2     = ps2;
        op.pd      = pd;
        op.rob_idx = rob_idx;
        return op;
    endfunction

    task automatic load_reg(input ooo_types::phys_reg_t pd, input rv32i_types::word_t value);
        @(negedge clk);
        ext_write.en    = 1'b1;
        ext_write.pd    = pd;
        ext_write.value = value;
        @(negedge clk);
        ext_write.en = 1'b0;
    endtask

    // Issue on one way and count edges until its result shows up
    task automatic run_op(input int way, input ooo_types::fu_input_t op,
                          output ooo_types::fu_output_t res, output int cycles);
        @(negedge clk);
        issue[way] = op;
        cycles = 0;
        do begin
            @(negedge clk);
            issue[way] = '0;
            cycles++;
        end while (!result[way].valid);
        res = result[way];
    endtask

    task automatic run_pair(input ooo_types::fu_input_t op0, input ooo_types::fu_input_t op1,
                            output ooo_types::fu_output_t res0,
                            output ooo_types::fu_output_t res1);
        @(negedge clk);
        issue[0] = op0;
        issue[1] = op1;
        @(negedge clk);
        issue[0] = '0;
        issue[1] = '0;
        res0 = result[0];
        res1 = result[1];
    endtask

    task automatic test_reset_state();
        ooo_types::fu_input_t  op;
        ooo_types::fu_output_t res;
        int cycles;
        for (int w = 0; w < ooo_types::SS; w++) begin
            check_equal("reset result valid", 0, result[w].valid);
            check_equal("reset mult_busy", 0, mult_busy[w]);
        end
        for (int r = 0; r < ooo_types::PHYS_REGS; r += 9) begin
            op = new_issue(rv32i_types::ALU, 0, r, 0, r);
            op.op1_sel = rv32i_types::ZERO;
            run_op(r % 2, op, res, cycles);
            check_result($sformatf("reset read p%0d", r), res, 0, 0, r);
            check_equal("reset alu latency", 1, cycles);
        end
    endtask

    task automatic test_alu_parallel();
        rv32i_types::alu_op_t  ops     [10];
        rv32i_types::word_t    exp_val [10];
        ooo_types::fu_input_t  op0;
        ooo_types::fu_input_t  op1;
        ooo_types::fu_output_t res0;
        ooo_types::fu_output_t res1;
        ops = '{rv32i_types::ADD, rv32i_types::SUB, rv32i_types::SLL, rv32i_types::SRL,
                rv32i_types::SRA, rv32i_types::SLT, rv32i_types::SLTU, rv32i_types::XOR,
                rv32i_types::OR, rv32i_types::AND};
        // Operands 0x80000010 and 0x24, so shifts move by 4
        exp_val = '{32'h8000_0034, 32'h7fff_ffec, 32'h0000_0100, 32'h0800_0001,
                    32'hf800_0001, 32'h0000_0001, 32'h0000_0000, 32'h8000_0034,
                    32'h8000_0034, 32'h0000_0000};
        load_reg(1, 32'h8000_0010);
        load_reg(2, 32'h0000_0024);
        for (int i = 0; i < 10; i += 2) begin
            op0 = new_issue(rv32i_types::ALU, 1, 2, 10 + i, i);
            op0.alu_op = ops[i];
            op1 = new_issue(rv32i_types::ALU, 1, 2, 11 + i, i + 1);
            op1.alu_op = ops[i + 1];
            run_pair(op0, op1, res0, res1);
            check_result({"alu ", ops[i].name()}, res0, exp_val[i], 10 + i, i);
            check_result({"alu ", ops[i + 1].name()}, res1, exp_val[i + 1], 11 + i, i + 1);
        end
        // Sums of ADD+SUB and SLL+SRL read what the result buses wrote
        op0 = new_issue(rv32i_types::ALU, 10, 11, 40, 2);
        op1 = new_issue(rv32i_types::ALU, 12, 13, 41, 3);
        run_pair(op0, op1, res0, res1);
        check_result("writeback way 0", res0, 32'h0000_0020, 40, 2);
        check_result("writeback way 1", res1, 32'h0800_0101, 41, 3);
    endtask

    task automatic test_imm_pc();
        ooo_types::fu_input_t  op;
        ooo_types::fu_output_t res;
        int cycles;
        op = new_issue(rv32i_types::ALU, 0, 0, 20, 3);
        op.op1_sel = rv32i_types::ZERO;
        op.op2_sel = rv32i_types::IMM;
        op.imm     = 32'h1234_5000;
        run_op(1, op, res, cycles);
        check_result("lui", res, 32'h1234_5000, 20, 3);
        op = new_issue(rv32i_types::ALU, 0, 0, 21, 4);
        op.op1_sel = rv32i_types::PC;
        op.op2_sel = rv32i_types::IMM;
        op.pc      = 32'h0040_0100;
        op.imm     = 32'h0000_2000;
        run_op(0, op, res, cycles);
        check_result("auipc", res, 32'h0040_2100, 21, 4);
        op = new_issue(rv32i_types::ALU, 20, 21, 22, 5);
        run_op(0, op, res, cycles);
        check_result("lui plus auipc", res, 32'h1274_7100, 22, 5);
        // Neither a way result nor the external port may change p0
        op = new_issue(rv32i_types::ALU, 0, 0, 0, 6);
        op.op1_sel = rv32i_types::ZERO;
        op.op2_sel = rv32i_types::IMM;
        op.imm     = 32'hdead_beef;
        run_op(1, op, res, cycles);
        check_result("write p0", res, 32'hdead_beef, 0, 6);
        load_reg(0, 32'h5555_aaaa);
        op = new_issue(rv32i_types::ALU, 0, 0, 23, 7);
        run_op(0, op, res, cycles);
        check_result("read p0", res, 0, 23, 7);
    endtask

    task automatic test_branch_jump();
        rv32i_types::cmp_op_t  cops [6];
        rv32i_types::word_t    a;
        rv32i_types::word_t    b;
        rv32i_types::word_t    imm;
        rv32i_types::word_t    target;
        logic                  taken;
        ooo_types::fu_input_t  op;
        ooo_types::fu_output_t res;
        int cycles;
        cops = '{rv32i_types::BEQ, rv32i_types::BNE, rv32i_types::BLT,
                 rv32i_types::BGE, rv32i_types::BLTU, rv32i_types::BGEU};
        for (int i = 0; i < 6; i++) begin
            a = $random(seed);
            b = (i == 0 || i == 3) ? a : $random(seed);
            imm = $random(seed);
            imm[0] = 1'b0;
            load_reg(30, a);
            load_reg(31, b);
            // Signed order equals unsigned order with the sign bits flipped
            case (cops[i])
                rv32i_types::BEQ:  taken = (a == b);
                rv32i_types::BNE:  taken = (a != b);
                rv32i_types::BLT:  taken = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
                rv32i_types::BGE:  taken = !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
                rv32i_types::BLTU: taken = (a < b);
                default:           taken = !(a < b);
            endcase
            op = new_issue(rv32i_types::BRANCH, 30, 31, 9, i);
            op.cmp_op = cops[i];
            op.pc     = 32'h0000_1000 + 16 * i;
            op.imm    = imm;
            target    = op.pc + imm;
            run_op(i % 2, op, res, cycles);
            check_result({"branch ", cops[i].name()}, res, 0, 0, i);
            check_equal({"branch ", cops[i].name(), " taken"}, taken, res.branch_taken);
            check_equal({"branch ", cops[i].name(), " target"}, target, res.target);
        end
        op = new_issue(rv32i_types::JUMP, 0, 0, 25, 5);
        op.op1_sel = rv32i_types::PC;
        op.pc      = 32'h0000_2000;
        op.imm     = 32'h0000_0040;
        run_op(0, op, res, cycles);
        check_result("jal", res, 32'h0000_2004, 25, 5);
        check_equal("jal target", 32'h0000_2040, res.target);
        // p30 still holds the last branch operand
        op = new_issue(rv32i_types::JUMP, 30, 0, 26, 6);
        op.pc  = 32'h0000_3000;
        op.imm = 32'h0000_0013;
        target = (a + 32'h13) & 32'hffff_fffe;
        run_op(1, op, res, cycles);
        check_result("jalr", res, 32'h0000_3004, 26, 6);
        check_equal("jalr target", target, res.target);
    endtask

    task automatic test_multiply();
        rv32i_types::mul_type_t mts [4];
        rv32i_types::word_t     a;
        rv32i_types::word_t     b;
        rv32i_types::word_t     expected;
        logic [63:0]            prod;
        ooo_types::rob_idx_t    rob;
        ooo_types::fu_input_t   op;
        ooo_types::fu_output_t  res;
        int cycles;
        mts = '{rv32i_types::MUL, rv32i_types::MULH, rv32i_types::MULHSU, rv32i_types::MULHU};
        for (int t = 0; t < 4; t++) begin
            for (int k = 0; k < 3; k++) begin
                if (k == 0) begin
                    a = $random(seed);
                    b = $random(seed);
                end else if (k == 1) begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end else begin
                    a = 32'h7fff_ffff;
                    b = 32'h8000_0000;
                end
                load_reg(32, a);
                load_reg(33, b);
                // Extended operands multiplied modulo 2^64
                case (mts[t])
                    rv32i_types::MULH:   prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    rv32i_types::MULHSU: prod = {{32{a[31]}}, a} * {32'b0, b};
                    default:             prod = {32'b0, a} * {32'b0, b};
                endcase
                expected = (mts[t] == rv32i_types::MUL) ? prod[31:0] : prod[63:32];
                rob = t * 3 + k;
                op = new_issue(rv32i_types::MULT, 32, 33, 34 + k, rob);
                op.mul_type = mts[t];
                run_op(t % 2, op, res, cycles);
                check_result({"multiply ", mts[t].name()}, res, expected, 34 + k, rob);
                check_equal("multiply latency", ooo_types::MUL_LATENCY, cycles);
                check_equal("mult_busy after result", 0, mult_busy[t % 2]);
            end
        end
    endtask

    task automatic test_mult_overlap();
        rv32i_types::word_t   a;
        rv32i_types::word_t   b;
        logic [63:0]          prod;
        ooo_types::fu_input_t mul_op;
        ooo_types::fu_input_t add_op;
        logic                 pending;
        int cycles;
        int sent;
        a    = 32'h0001_0003;
        b    = 32'hffff_fffe;
        prod = {32'b0, a} * {32'b0, b};
        load_reg(35, a);
        load_reg(36, b);
        mul_op  = new_issue(rv32i_types::MULT, 35, 36, 37, 1);
        cycles  = 0;
        sent    = 0;
        pending = 1'b0;
        @(negedge clk);
        issue[0] = mul_op;
        do begin
            @(negedge clk);
            cycles++;
            issue[0] = '0;
            if (pending) begin
                check_result("alu beside multiply", result[1], 32'h100 + sent - 1,
                             40 + sent - 1, sent - 1);
            end
            if (!result[0].valid) begin
                check_equal("mult_busy while multiplying", 1, mult_busy[0]);
            end
            pending = (sent < 20);
            if (pending) begin
                add_op = new_issue(rv32i_types::ALU, 0, 0, 40 + sent, sent);
                add_op.op1_sel = rv32i_types::ZERO;
                add_op.op2_sel = rv32i_types::IMM;
                add_op.imm     = 32'h100 + sent;
                issue[1] = add_op;
                sent++;
            end else begin
                issue[1] = '0;
            end
        end while (!result[0].valid);
        issue[1] = '0;
        check_result("multiply beside alu", result[0], prod[31:0], 37, 1);
        check_equal("overlap multiply latency", ooo_types::MUL_LATENCY, cycles);
        check_equal("mult_busy at multiply result", 0, mult_busy[0]);
    endtask

    initial begin
        seed      = 7;
        rst       = 1'b1;
        ext_write = '0;
        for (int w = 0; w < ooo_types::SS; w++) begin
            issue[w] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_alu_parallel();
        test_imm_pc();
        test_branch_jump();
        test_multiply();
        test_mult_overlap();
        if (UUT.u_fu.u_properties.fail_count != 0) begin
            $display("A bound assertion on the functional units failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failed");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
verilog/rv32i_types.sv
verilog/ooo_types.sv
verilog/alu.sv
verilog/cmp.sv
verilog/shift_add_multiplier.sv
verilog/fu_wrapper.sv
verilog/phys_regfile.sv
verilog/execute_stage.sv
sim/execute_stage_properties.sv
sim/execute_stage_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - files:
      - verilog/rv32i_types.sv
      - verilog/ooo_types.sv
      - verilog/alu.sv
      - verilog/cmp.sv
      - verilog/shift_add_multiplier.sv
      - verilog/fu_wrapper.sv
      - verilog/phys_regfile.sv
      - verilog/execute_stage.sv
  - target: simulation
    files:
      - sim/execute_stage_properties.sv
      - sim/execute_stage_tb.sv
